// ==== lx_cache.f ====
verilog/lx_msg_pkg.sv
verilog/lx_line_pkg.sv
verilog/lx_arbiter.sv
verilog/lx_way_ram.sv
verilog/lx_lookup.sv
verilog/lx_lru.sv
verilog/lx_controller.sv
verilog/lx_cache.sv
+incdir+tests
tests/lx_cache_tb.sv

// ==== tests/lx_cache_checks.svh ====
// LFSR stimulus, reference line model, compare tasks and test sequences
`ifndef LX_CACHE_CHECKS_SVH
`define LX_CACHE_CHECKS_SVH

// 16-bit Galois LFSR, shifts right
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
	logic out_bit;
	out_bit = s[0];
	s = s >> 1;
	if (out_bit)
		s = s ^ 16'hB400;
	return s;
endfunction

// One LFSR step per bit taken
function automatic logic [31:0] random_bits(input int count);
	logic [31:0] value;
	value = '0;
	for (int i = 0; i < count; i++) begin
		value = {value[30:0], lfsr_state[0]};
		lfsr_state = lfsr_step(lfsr_state);
	end
	return value;
endfunction

function automatic logic [LINE_DATA_BITS-1:0] random_line();
	logic [LINE_DATA_BITS-1:0] line;
	for (int k = 0; k < WORDS; k++)
		line[k*DATA_WIDTH +: DATA_WIDTH] = random_bits(DATA_WIDTH);
	return line;
endfunction

function automatic logic [ADDRESS_WIDTH-1:0] line_of(input logic [ADDRESS_WIDTH-1:0] addr);
	return {addr[ADDRESS_WIDTH-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
endfunction

function automatic logic [ADDRESS_WIDTH-1:0] make_addr(input int tag_value, input int set);
	return {TAG_BITS'(tag_value), INDEX_BITS'(set), {OFFSET_BITS{1'b0}}};
endfunction

// Memory contents before any write-back
function automatic logic [LINE_DATA_BITS-1:0] init_line(
		input logic [ADDRESS_WIDTH-1:0] line_addr);
	logic [LINE_DATA_BITS-1:0] line;
	logic [DATA_WIDTH-1:0] word;
	for (int k = 0; k < WORDS; k++) begin
		word = (line_addr + ADDRESS_WIDTH'(k)) * 32'h9E37_79B1;
		line[k*DATA_WIDTH +: DATA_WIDTH] = word ^ {line_addr[15:0], line_addr[31:16]};
	end
	return line;
endfunction

// Last line written by either cache, else memory's initial pattern
function automatic logic [LINE_DATA_BITS-1:0] expected_line(
		input logic [ADDRESS_WIDTH-1:0] addr);
	if (written_lines.exists(line_of(addr)))
		return written_lines[line_of(addr)];
	return init_line(line_of(addr));
endfunction

task automatic check_line(input string name, input logic [LINE_DATA_BITS-1:0] got,
		input logic [LINE_DATA_BITS-1:0] want);
	if (got !== want) begin
		line_errors++;
		$display("CHECK FAILED %s got %h expected %h", name, got, want);
	end
endtask

task automatic check_msg(input string name, input msg_t got, input msg_t want);
	if (got !== want) begin
		msg_errors++;
		$display("CHECK FAILED %s got %h expected %h", name, got, want);
	end
endtask

task automatic check_address(input string name, input logic [ADDRESS_WIDTH-1:0] got,
		input logic [ADDRESS_WIDTH-1:0] want);
	if (got !== want) begin
		address_errors++;
		$display("CHECK FAILED %s got %h expected %h", name, got, want);
	end
endtask

task automatic note_failure(input string text);
	other_errors++;
	$display("ERROR %s", text);
endtask

task automatic expect_hit_latency(input int latency, input string what);
	if (latency != HIT_LATENCY)
		note_failure($sformatf("%s hit answered after %0d cycles instead of %0d",
			what, latency, HIT_LATENCY));
endtask

task automatic clear_memory_log();
	mem_log_msg.delete();
	mem_log_addr.delete();
	mem_log_data.delete();
endtask

task automatic expect_memory_count(input int count);
	if (mem_log_msg.size() != count)
		note_failure($sformatf("memory saw %0d requests where %0d were expected",
			mem_log_msg.size(), count));
endtask

task automatic expect_memory_op(input int i, input msg_t kind,
		input logic [ADDRESS_WIDTH-1:0] addr);
	if (i >= mem_log_msg.size()) begin
		note_failure($sformatf("memory request %0d never arrived", i));
	end else begin
		check_msg("cache2mem_msg", mem_log_msg[i], kind);
		check_address("cache2mem_address", mem_log_addr[i], addr);
		if (kind == WB_REQ)
			check_line("cache2mem_data", mem_log_data[i], expected_line(addr));
	end
endtask

// Requests held from the end of reset wait out the sweep
task automatic sweep_and_fresh_reads();
	int latency;
	run_request(0, R_REQ, make_addr(5, 1), '0, latency);
	if (latency <= SWEEP_CYCLES)
		note_failure($sformatf("first read answered after %0d cycles, during the sweep",
			latency));
	run_request(1, R_REQ, make_addr(9, 2), '0, latency);
	run_request(0, R_REQ, make_addr(7, 4), '0, latency);
endtask

task automatic write_then_read();
	logic [ADDRESS_WIDTH-1:0] a;
	int latency;
	a = make_addr(20, 6);
	run_request(0, WB_REQ, a, random_line(), latency);
	run_request(1, R_REQ, a, '0, latency);
	expect_hit_latency(latency, "read");
	run_request(1, R_REQ, a, '0, latency);
	expect_hit_latency(latency, "repeated read");
	run_request(1, WB_REQ, a, random_line(), latency);
	expect_hit_latency(latency, "write");
	run_request(0, R_REQ, a, '0, latency);
	expect_hit_latency(latency, "read");
endtask

// Set 9, ways fill with A and B, then C forces evictions
task automatic eviction_sequence();
	logic [ADDRESS_WIDTH-1:0] a;
	logic [ADDRESS_WIDTH-1:0] b;
	logic [ADDRESS_WIDTH-1:0] c;
	int latency;
	a = make_addr(30, 9);
	b = make_addr(31, 9);
	c = make_addr(32, 9);
	run_request(0, R_REQ, a, '0, latency);
	run_request(1, WB_REQ, b, random_line(), latency);
	run_request(0, R_REQ, a, '0, latency);
	clear_memory_log();
	run_request(1, WB_REQ, c, random_line(), latency);
	expect_memory_count(1);
	expect_memory_op(0, WB_REQ, b);
	// Clean A goes quietly
	clear_memory_log();
	run_request(0, R_REQ, b, '0, latency);
	expect_memory_count(1);
	expect_memory_op(0, R_REQ, b);
	run_request(1, R_REQ, c, '0, latency);
	clear_memory_log();
	run_request(1, R_REQ, a, '0, latency);
	expect_memory_count(1);
	expect_memory_op(0, R_REQ, a);
	clear_memory_log();
	run_request(0, R_REQ, b, '0, latency);
	expect_memory_count(2);
	expect_memory_op(0, WB_REQ, c);
	expect_memory_op(1, R_REQ, b);
endtask

// Both caches ask again right after each answer, so every grant
// finds the other cache still waiting
task automatic simultaneous_rounds();
	int latency_0;
	int latency_1;
	answer_order.delete();
	fork
		begin
			for (int r = 0; r < ROUNDS; r++)
				run_request(0, R_REQ, make_addr(40 + r, 12), '0, latency_0);
		end
		begin
			for (int r = 0; r < ROUNDS; r++)
				run_request(1, R_REQ, make_addr(50 + r, 13), '0, latency_1);
		end
	join
	if (answer_order.size() != 2 * ROUNDS)
		note_failure($sformatf("%0d answers in the simultaneous rounds, expected %0d",
			answer_order.size(), 2 * ROUNDS));
	for (int i = 1; i < answer_order.size(); i++) begin
		if (answer_order[i] == answer_order[i-1])
			note_failure($sformatf("cache %0d granted twice in a row at answer %0d",
				answer_order[i], i));
	end
endtask

`endif

// ==== tests/lx_cache_tb.sv ====
// Testbench top: clock, reset, DUT, requester and memory models, timeout and report
`timescale 1ns/1ps

module lx_cache_tb
	import lx_msg_pkg::*;
	import lx_line_pkg::*;
();

	localparam int DATA_WIDTH = 32;
	localparam int OFFSET_BITS = 2;
	localparam int INDEX_BITS = 4;
	localparam int ADDRESS_WIDTH = 32;
	localparam int NUMBER_OF_WAYS = 2;
	localparam int NUM_CACHES = 2;
	localparam int LINE_DATA_BITS = DATA_WIDTH << OFFSET_BITS;
	localparam int TAG_BITS = ADDRESS_WIDTH - INDEX_BITS - OFFSET_BITS;
	localparam int WORDS = 1 << OFFSET_BITS;
	localparam int SWEEP_CYCLES = 1 << INDEX_BITS;
	localparam int RESET_CYCLES = 2;
	localparam int HIT_LATENCY = 4;
	localparam int ROUNDS = 4;
	localparam int TOTAL_REQUESTS = 16 + 2 * ROUNDS;
	localparam int TIMEOUT_CYCLES = 40 * TOTAL_REQUESTS + SWEEP_CYCLES + RESET_CYCLES;

	logic clock;
	logic reset;
	logic [NUM_CACHES-1:0][ADDRESS_WIDTH-1:0] address;
	logic [NUM_CACHES-1:0][LINE_DATA_BITS-1:0] data_in;
	msg_t [NUM_CACHES-1:0] msg_in;
	msg_t mem2cache_msg;
	logic [LINE_DATA_BITS-1:0] mem2cache_data;
	logic [NUM_CACHES-1:0][LINE_DATA_BITS-1:0] data_out;
	logic [NUM_CACHES-1:0][ADDRESS_WIDTH-1:0] out_address;
	msg_t [NUM_CACHES-1:0] msg_out;
	msg_t cache2mem_msg;
	logic [ADDRESS_WIDTH-1:0] cache2mem_address;
	logic [LINE_DATA_BITS-1:0] cache2mem_data;
	ctrl_state_t dut_state;

	logic [15:0] lfsr_state = 16'd65;
	int cycle_count = 0;
	int line_errors = 0;
	int msg_errors = 0;
	int address_errors = 0;
	int other_errors = 0;
	logic [ADDRESS_WIDTH-1:0] issued_address [NUM_CACHES];
	logic [LINE_DATA_BITS-1:0] issued_data [NUM_CACHES];
	logic [LINE_DATA_BITS-1:0] written_lines [logic [ADDRESS_WIDTH-1:0]];
	logic [LINE_DATA_BITS-1:0] memory_lines [logic [ADDRESS_WIDTH-1:0]];
	msg_t mem_log_msg [$];
	logic [ADDRESS_WIDTH-1:0] mem_log_addr [$];
	logic [LINE_DATA_BITS-1:0] mem_log_data [$];
	int answer_order [$];

	`include "lx_cache_checks.svh"

	lx_cache #(
		.DATA_WIDTH(DATA_WIDTH),
		.OFFSET_BITS(OFFSET_BITS),
		.INDEX_BITS(INDEX_BITS),
		.ADDRESS_WIDTH(ADDRESS_WIDTH),
		.NUMBER_OF_WAYS(NUMBER_OF_WAYS),
		.NUM_CACHES(NUM_CACHES)
	) lx_cache_inst (
		.clock(clock),
		.reset(reset),
		.address(address),
		.data_in(data_in),
		.msg_in(msg_in),
		.mem2cache_msg(mem2cache_msg),
		.mem2cache_data(mem2cache_data),
		.data_out(data_out),
		.out_address(out_address),
		.msg_out(msg_out),
		.cache2mem_msg(cache2mem_msg),
		.cache2mem_address(cache2mem_address),
		.cache2mem_data(cache2mem_data)
	);

	assign dut_state = lx_cache_inst.controller_inst.state;

	always #4 clock = ~clock;

	// Upper cache: hold the request until answered, then drop it
	task automatic run_request(input int c, input msg_t kind,
			input logic [ADDRESS_WIDTH-1:0] addr, input logic [LINE_DATA_BITS-1:0] data,
			output int latency);
		msg_t want;
		want = (kind == R_REQ) ? MEM_SENT : MEM_READY;
		latency = 0;
		@(negedge clock);
		issued_address[c] = addr;
		issued_data[c] = data;
		address[c] = addr;
		data_in[c] = data;
		msg_in[c] = kind;
		do begin
			@(negedge clock);
			latency++;
		end while (msg_out[c] == MEM_NO_MSG);
		check_msg("msg_out", msg_out[c], want);
		msg_in[c] = NO_REQ;
	endtask

	// Memory answers after 0 to 7 idle cycles
	always begin : memory_model
		int delay;
		@(negedge clock);
		mem2cache_msg = MEM_NO_MSG;
		if (!reset && (cache2mem_msg == WB_REQ || cache2mem_msg == R_REQ)) begin
			mem_log_msg.push_back(cache2mem_msg);
			mem_log_addr.push_back(cache2mem_address);
			mem_log_data.push_back(cache2mem_data);
			delay = random_bits(3);
			repeat (delay) @(negedge clock);
			if (cache2mem_msg == WB_REQ) begin
				memory_lines[cache2mem_address] = cache2mem_data;
				mem2cache_msg = MEM_READY;
			end else begin
				if (memory_lines.exists(cache2mem_address))
					mem2cache_data = memory_lines[cache2mem_address];
				else
					mem2cache_data = init_line(cache2mem_address);
				mem2cache_msg = MEM_SENT;
			end
		end
	end

	// Answer checker, compares every pulse on msg_out with the reference
	always @(negedge clock) begin
		if (!reset) begin
			for (int c = 0; c < NUM_CACHES; c++) begin
				if (msg_out[c] != MEM_NO_MSG) begin
					answer_order.push_back(c);
					check_address("out_address", out_address[c], issued_address[c]);
				end
				if (msg_out[c] == MEM_SENT)
					check_line("data_out", data_out[c], expected_line(issued_address[c]));
				else if (msg_out[c] == MEM_READY)
					written_lines[line_of(issued_address[c])] = issued_data[c];
			end
		end
	end

	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, controller stuck in %s",
				cycle_count, dut_state.name());
			$display("Simulation failed");
			$finish;
		end
	end

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		address = '0;
		data_in = '0;
		for (int c = 0; c < NUM_CACHES; c++)
			msg_in[c] = NO_REQ;
		mem2cache_msg = MEM_NO_MSG;
		mem2cache_data = '0;
		repeat (RESET_CYCLES) @(negedge clock);
		reset = 1'b0;

		sweep_and_fresh_reads();
		write_then_read();
		eviction_sequence();
		simultaneous_rounds();

		@(negedge clock);
		$display("Errors: %0d line, %0d message, %0d address, %0d other",
			line_errors, msg_errors, address_errors, other_errors);
		if (line_errors + msg_errors + address_errors + other_errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== verilog/lx_arbiter.sv ====
// Round-robin arbiter over the upper-cache requesters
`timescale 1ns/1ps

module lx_arbiter #(
	parameter int NUM_CACHES = 2,
	localparam int CACHE_BITS = $clog2(NUM_CACHES)
) (
	input logic clock,
	input logic reset,
	input logic [NUM_CACHES-1:0] requests,
	output logic [CACHE_BITS-1:0] serve_next
);

	// Requester with top priority this round
	logic [CACHE_BITS-1:0] first;
	logic [NUM_CACHES-1:0] last_requests;

	always_comb begin : pick
		int cand;
		logic found;
		serve_next = first;
		found = 1'b0;
		for (int i = 0; i < NUM_CACHES; i++) begin
			cand = int'(first) + i;
			if (cand >= NUM_CACHES)
				cand = cand - NUM_CACHES;
			if (requests[cand] && !found) begin
				serve_next = CACHE_BITS'(cand);
				found = 1'b1;
			end
		end
	end

	// A requester drops its request only once answered, so a falling
	// request marks the last granted cache
	always_ff @(posedge clock) begin
		if (reset) begin
			first <= '0;
			last_requests <= '0;
		end else begin
			last_requests <= requests;
			for (int c = 0; c < NUM_CACHES; c++) begin
				if (last_requests[c] && !requests[c])
					first <= (c == NUM_CACHES - 1) ? '0 : CACHE_BITS'(c + 1);
			end
		end
	end

endmodule

// ==== verilog/lx_cache.sv ====
// Shared second-level cache top level: controller, arbiter, lookup, LRU and way RAMs
`timescale 1ns/1ps

module lx_cache
	import lx_msg_pkg::*;
	import lx_line_pkg::*;
#(
	parameter int DATA_WIDTH = 32,
	parameter int OFFSET_BITS = 2,
	parameter int INDEX_BITS = 4,
	parameter int ADDRESS_WIDTH = 32,
	parameter int NUMBER_OF_WAYS = 2,
	parameter int NUM_CACHES = 2,
	localparam int LINE_DATA_BITS = DATA_WIDTH << OFFSET_BITS,
	localparam int TAG_BITS = ADDRESS_WIDTH - INDEX_BITS - OFFSET_BITS,
	localparam int LINE_WIDTH = STATUS_BITS + TAG_BITS + LINE_DATA_BITS,
	localparam int WAY_BITS = $clog2(NUMBER_OF_WAYS),
	localparam int CACHE_BITS = $clog2(NUM_CACHES)
) (
	input logic clock,
	input logic reset,
	input logic [NUM_CACHES-1:0][ADDRESS_WIDTH-1:0] address,
	input logic [NUM_CACHES-1:0][LINE_DATA_BITS-1:0] data_in,
	input msg_t [NUM_CACHES-1:0] msg_in,
	input msg_t mem2cache_msg,
	input logic [LINE_DATA_BITS-1:0] mem2cache_data,
	output logic [NUM_CACHES-1:0][LINE_DATA_BITS-1:0] data_out,
	output logic [NUM_CACHES-1:0][ADDRESS_WIDTH-1:0] out_address,
	output msg_t [NUM_CACHES-1:0] msg_out,
	output msg_t cache2mem_msg,
	output logic [ADDRESS_WIDTH-1:0] cache2mem_address,
	output logic [LINE_DATA_BITS-1:0] cache2mem_data
);

	logic [NUM_CACHES-1:0] requests;
	logic [CACHE_BITS-1:0] serve_next;
	logic [INDEX_BITS-1:0] index;
	logic [TAG_BITS-1:0] tag;
	logic [NUMBER_OF_WAYS-1:0] we;
	logic [LINE_WIDTH-1:0] wdata;
	logic [NUMBER_OF_WAYS-1:0][LINE_WIDTH-1:0] lines;
	logic hit;
	logic [WAY_BITS-1:0] matched_way;
	logic [WAY_BITS-1:0] victim_way;
	logic victim_dirty;
	logic [TAG_BITS-1:0] victim_tag;
	logic [LINE_DATA_BITS-1:0] line_data;
	logic access_valid;
	logic [WAY_BITS-1:0] access_way;
	logic [WAY_BITS-1:0] lru_way;

	lx_controller #(
		.DATA_WIDTH(DATA_WIDTH),
		.OFFSET_BITS(OFFSET_BITS),
		.INDEX_BITS(INDEX_BITS),
		.ADDRESS_WIDTH(ADDRESS_WIDTH),
		.NUMBER_OF_WAYS(NUMBER_OF_WAYS),
		.NUM_CACHES(NUM_CACHES)
	) controller_inst (
		.clock(clock),
		.reset(reset),
		.address(address),
		.data_in(data_in),
		.msg_in(msg_in),
		.serve_next(serve_next),
		.hit(hit),
		.matched_way(matched_way),
		.victim_way(victim_way),
		.victim_dirty(victim_dirty),
		.victim_tag(victim_tag),
		.line_data(line_data),
		.mem2cache_msg(mem2cache_msg),
		.mem2cache_data(mem2cache_data),
		.requests(requests),
		.index(index),
		.tag(tag),
		.we(we),
		.wdata(wdata),
		.access_valid(access_valid),
		.access_way(access_way),
		.data_out(data_out),
		.out_address(out_address),
		.msg_out(msg_out),
		.cache2mem_msg(cache2mem_msg),
		.cache2mem_address(cache2mem_address),
		.cache2mem_data(cache2mem_data)
	);

	lx_arbiter #(
		.NUM_CACHES(NUM_CACHES)
	) arbiter_inst (
		.clock(clock),
		.reset(reset),
		.requests(requests),
		.serve_next(serve_next)
	);

	for (genvar w = 0; w < NUMBER_OF_WAYS; w++) begin : way
		lx_way_ram #(
			.DATA_WIDTH(DATA_WIDTH),
			.OFFSET_BITS(OFFSET_BITS),
			.INDEX_BITS(INDEX_BITS),
			.ADDRESS_WIDTH(ADDRESS_WIDTH)
		) ram_inst (
			.clock(clock),
			.we(we[w]),
			.index(index),
			.wdata(wdata),
			.rdata(lines[w])
		);
	end

	lx_lookup #(
		.DATA_WIDTH(DATA_WIDTH),
		.OFFSET_BITS(OFFSET_BITS),
		.INDEX_BITS(INDEX_BITS),
		.ADDRESS_WIDTH(ADDRESS_WIDTH),
		.NUMBER_OF_WAYS(NUMBER_OF_WAYS)
	) lookup_inst (
		.lines(lines),
		.tag(tag),
		.lru_way(lru_way),
		.hit(hit),
		.matched_way(matched_way),
		.victim_way(victim_way),
		.victim_dirty(victim_dirty),
		.victim_tag(victim_tag),
		.line_data(line_data)
	);

	lx_lru #(
		.INDEX_BITS(INDEX_BITS),
		.NUMBER_OF_WAYS(NUMBER_OF_WAYS)
	) lru_inst (
		.clock(clock),
		.reset(reset),
		.index(index),
		.access_valid(access_valid),
		.access_way(access_way),
		.lru_way(lru_way)
	);

endmodule

// ==== verilog/lx_controller.sv ====
// Cache controller FSM: request handling, memory sequencing and line writes
`timescale 1ns/1ps

module lx_controller
	import lx_msg_pkg::*;
	import lx_line_pkg::*;
#(
	parameter int DATA_WIDTH = 32,
	parameter int OFFSET_BITS = 2,
	parameter int INDEX_BITS = 4,
	parameter int ADDRESS_WIDTH = 32,
	parameter int NUMBER_OF_WAYS = 2,
	parameter int NUM_CACHES = 2,
	localparam int LINE_DATA_BITS = DATA_WIDTH << OFFSET_BITS,
	localparam int TAG_BITS = ADDRESS_WIDTH - INDEX_BITS - OFFSET_BITS,
	localparam int LINE_WIDTH = STATUS_BITS + TAG_BITS + LINE_DATA_BITS,
	localparam int WAY_BITS = $clog2(NUMBER_OF_WAYS),
	localparam int CACHE_BITS = $clog2(NUM_CACHES)
) (
	input logic clock,
	input logic reset,
	input logic [NUM_CACHES-1:0][ADDRESS_WIDTH-1:0] address,
	input logic [NUM_CACHES-1:0][LINE_DATA_BITS-1:0] data_in,
	input msg_t [NUM_CACHES-1:0] msg_in,
	input logic [CACHE_BITS-1:0] serve_next,
	input logic hit,
	input logic [WAY_BITS-1:0] matched_way,
	input logic [WAY_BITS-1:0] victim_way,
	input logic victim_dirty,
	input logic [TAG_BITS-1:0] victim_tag,
	input logic [LINE_DATA_BITS-1:0] line_data,
	input msg_t mem2cache_msg,
	input logic [LINE_DATA_BITS-1:0] mem2cache_data,
	output logic [NUM_CACHES-1:0] requests,
	output logic [INDEX_BITS-1:0] index,
	output logic [TAG_BITS-1:0] tag,
	output logic [NUMBER_OF_WAYS-1:0] we,
	output logic [LINE_WIDTH-1:0] wdata,
	output logic access_valid,
	output logic [WAY_BITS-1:0] access_way,
	output logic [NUM_CACHES-1:0][LINE_DATA_BITS-1:0] data_out,
	output logic [NUM_CACHES-1:0][ADDRESS_WIDTH-1:0] out_address,
	output msg_t [NUM_CACHES-1:0] msg_out,
	output msg_t cache2mem_msg,
	output logic [ADDRESS_WIDTH-1:0] cache2mem_address,
	output logic [LINE_DATA_BITS-1:0] cache2mem_data
);

	ctrl_state_t state;
	logic [INDEX_BITS-1:0] sweep_count;
	logic lookup_wait;
	logic [CACHE_BITS-1:0] serving;
	msg_t t_msg;
	logic [ADDRESS_WIDTH-1:0] t_address;
	logic [LINE_DATA_BITS-1:0] t_data;
	logic [LINE_DATA_BITS-1:0] t_line;
	logic [WAY_BITS-1:0] t_way;
	logic [ADDRESS_WIDTH-1:0] line_address;
	logic [STATUS_BITS-1:0] wstatus;
	logic out_idle;
	logic accept;
	logic resolve;

	always_comb begin
		out_idle = 1'b1;
		for (int c = 0; c < NUM_CACHES; c++) begin
			requests[c] = (msg_in[c] == R_REQ) || (msg_in[c] == WB_REQ);
			out_idle = out_idle && (msg_out[c] == MEM_NO_MSG);
		end
	end

	assign accept = (state == IDLE) && (|requests) && out_idle;
	// RAM output for the latched index is ready one cycle into LOOKUP
	assign resolve = (state == LOOKUP) && !lookup_wait;

	assign index = (state == SWEEP) ? sweep_count : t_address[OFFSET_BITS +: INDEX_BITS];
	assign tag = t_address[ADDRESS_WIDTH-1 -: TAG_BITS];
	assign line_address = {t_address[ADDRESS_WIDTH-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};

	// Fills store clean lines, writes from above store dirty ones
	always_comb begin
		wstatus = '0;
		wstatus[STATUS_BITS-1-VALID_POS] = 1'b1;
		if (state == WRITE)
			wstatus[STATUS_BITS-1-DIRTY_POS] = 1'b1;
		if (state == SWEEP)
			wdata = '0;
		else
			wdata = {wstatus, tag, (state == WRITE) ? t_data : t_line};
		for (int w = 0; w < NUMBER_OF_WAYS; w++)
			we[w] = (state == SWEEP) ||
				(((state == WRITE) || (state == UPDATE)) && (t_way == WAY_BITS'(w)));
	end

	assign access_valid = (state == READ_OUT) || (state == WRITE);
	assign access_way = t_way;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= SWEEP;
			sweep_count <= '0;
			lookup_wait <= 1'b0;
			serving <= '0;
			cache2mem_msg <= NO_REQ;
			for (int c = 0; c < NUM_CACHES; c++)
				msg_out[c] <= MEM_NO_MSG;
		end else begin
			case (state)
				SWEEP: begin
					sweep_count <= sweep_count + 1'b1;
					if (&sweep_count)
						state <= IDLE;
				end
				IDLE: begin
					for (int c = 0; c < NUM_CACHES; c++)
						msg_out[c] <= MEM_NO_MSG;
					if (accept) begin
						serving <= serve_next;
						lookup_wait <= 1'b1;
						state <= LOOKUP;
					end
				end
				LOOKUP: begin
					lookup_wait <= 1'b0;
					if (resolve) begin
						if (hit)
							state <= (t_msg == R_REQ) ? READ_OUT : WRITE;
						else if (victim_dirty) begin
							cache2mem_msg <= WB_REQ;
							state <= WRITE_BACK;
						end else if (t_msg == R_REQ) begin
							cache2mem_msg <= R_REQ;
							state <= READ_MEM;
						end else
							state <= WRITE;
					end
				end
				WRITE_BACK: begin
					if (mem2cache_msg == MEM_READY) begin
						cache2mem_msg <= (t_msg == R_REQ) ? R_REQ : NO_REQ;
						state <= (t_msg == R_REQ) ? READ_MEM : WRITE;
					end
				end
				READ_MEM: begin
					if (mem2cache_msg == MEM_SENT) begin
						cache2mem_msg <= NO_REQ;
						state <= UPDATE;
					end
				end
				UPDATE: state <= READ_OUT;
				READ_OUT: begin
					msg_out[serving] <= MEM_SENT;
					state <= IDLE;
				end
				WRITE: begin
					msg_out[serving] <= MEM_READY;
					state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Request and line payload
	always_ff @(posedge clock) begin
		if (accept) begin
			t_msg <= msg_in[serve_next];
			t_address <= address[serve_next];
			t_data <= data_in[serve_next];
		end
		if (resolve) begin
			t_line <= line_data;
			t_way <= hit ? matched_way : victim_way;
			if (!hit && victim_dirty) begin
				cache2mem_address <= {victim_tag, index, {OFFSET_BITS{1'b0}}};
				cache2mem_data <= line_data;
			end else if (!hit)
				cache2mem_address <= line_address;
		end
		if ((state == WRITE_BACK) && (mem2cache_msg == MEM_READY))
			cache2mem_address <= line_address;
		if ((state == READ_MEM) && (mem2cache_msg == MEM_SENT))
			t_line <= mem2cache_data;
		if (state == READ_OUT)
			data_out[serving] <= t_line;
		if ((state == READ_OUT) || (state == WRITE))
			out_address[serving] <= t_address;
	end

endmodule

// ==== verilog/lx_line_pkg.sv ====
// Stored line layout constants and the controller state type
package lx_line_pkg;

	// Stored line is {status, tag, line data}, status on top
	localparam int STATUS_BITS = 2;

	// Offsets counted down from the top bit of a stored line
	localparam int VALID_POS = 0;
	localparam int DIRTY_POS = 1;

	typedef enum logic [3:0] {
		SWEEP,
		IDLE,
		LOOKUP,
		READ_OUT,
		WRITE,
		WRITE_BACK,
		READ_MEM,
		UPDATE
	} ctrl_state_t;

endpackage

// ==== verilog/lx_lookup.sv ====
// Tag compare over all ways, hit way encoding and victim selection
`timescale 1ns/1ps

module lx_lookup
	import lx_line_pkg::*;
#(
	parameter int DATA_WIDTH = 32,
	parameter int OFFSET_BITS = 2,
	parameter int INDEX_BITS = 4,
	parameter int ADDRESS_WIDTH = 32,
	parameter int NUMBER_OF_WAYS = 2,
	localparam int LINE_DATA_BITS = DATA_WIDTH << OFFSET_BITS,
	localparam int TAG_BITS = ADDRESS_WIDTH - INDEX_BITS - OFFSET_BITS,
	localparam int LINE_WIDTH = STATUS_BITS + TAG_BITS + LINE_DATA_BITS,
	localparam int WAY_BITS = $clog2(NUMBER_OF_WAYS)
) (
	input logic [NUMBER_OF_WAYS-1:0][LINE_WIDTH-1:0] lines,
	input logic [TAG_BITS-1:0] tag,
	input logic [WAY_BITS-1:0] lru_way,
	output logic hit,
	output logic [WAY_BITS-1:0] matched_way,
	output logic [WAY_BITS-1:0] victim_way,
	output logic victim_dirty,
	output logic [TAG_BITS-1:0] victim_tag,
	output logic [LINE_DATA_BITS-1:0] line_data
);

	logic [NUMBER_OF_WAYS-1:0] valid;
	logic [NUMBER_OF_WAYS-1:0] match;
	logic found_empty;
	logic [WAY_BITS-1:0] chosen;

	always_comb begin
		for (int w = 0; w < NUMBER_OF_WAYS; w++) begin
			valid[w] = lines[w][LINE_WIDTH-1-VALID_POS];
			match[w] = valid[w] && (lines[w][LINE_DATA_BITS +: TAG_BITS] == tag);
		end
	end

	// At most one way matches, so OR-ing indexes encodes it
	always_comb begin
		matched_way = '0;
		for (int w = 0; w < NUMBER_OF_WAYS; w++) begin
			if (match[w])
				matched_way = matched_way | WAY_BITS'(w);
		end
		hit = |match;
	end

	// Empty ways fill before anything is evicted
	always_comb begin
		victim_way = lru_way;
		found_empty = 1'b0;
		for (int w = 0; w < NUMBER_OF_WAYS; w++) begin
			if (!valid[w] && !found_empty) begin
				victim_way = WAY_BITS'(w);
				found_empty = 1'b1;
			end
		end
	end

	assign chosen = hit ? matched_way : victim_way;
	assign line_data = lines[chosen][0 +: LINE_DATA_BITS];
	assign victim_tag = lines[chosen][LINE_DATA_BITS +: TAG_BITS];
	assign victim_dirty = !hit && lines[chosen][LINE_WIDTH-1-DIRTY_POS];

endmodule

// ==== verilog/lx_lru.sv ====
// Per-set LRU age tracking and oldest way selection
`timescale 1ns/1ps

module lx_lru #(
	parameter int INDEX_BITS = 4,
	parameter int NUMBER_OF_WAYS = 2,
	localparam int WAY_BITS = $clog2(NUMBER_OF_WAYS),
	localparam int SETS = 1 << INDEX_BITS
) (
	input logic clock,
	input logic reset,
	input logic [INDEX_BITS-1:0] index,
	input logic access_valid,
	input logic [WAY_BITS-1:0] access_way,
	output logic [WAY_BITS-1:0] lru_way
);

	// Age 0 is most recent, NUMBER_OF_WAYS-1 is the oldest
	logic [WAY_BITS-1:0] age [SETS][NUMBER_OF_WAYS];
	logic [WAY_BITS-1:0] touched_age;

	assign touched_age = age[index][access_way];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int s = 0; s < SETS; s++) begin
				for (int w = 0; w < NUMBER_OF_WAYS; w++)
					age[s][w] <= WAY_BITS'(w);
			end
		end else if (access_valid) begin
			for (int w = 0; w < NUMBER_OF_WAYS; w++) begin
				if (WAY_BITS'(w) == access_way)
					age[index][w] <= '0;
				else if (age[index][w] < touched_age)
					age[index][w] <= age[index][w] + 1'b1;
			end
		end
	end

	// Ages stay a permutation, so exactly one way is oldest
	always_comb begin
		lru_way = '0;
		for (int w = 0; w < NUMBER_OF_WAYS; w++) begin
			if (age[index][w] == WAY_BITS'(NUMBER_OF_WAYS - 1))
				lru_way = WAY_BITS'(w);
		end
	end

endmodule

// ==== verilog/lx_msg_pkg.sv ====
// Message codes for the upper-cache and memory buses
package lx_msg_pkg;

	localparam int MSG_BITS = 3;

	// Requests come from the upper caches and go out to memory.
	// Answers come from memory and go back up to the upper caches.
	typedef enum logic [MSG_BITS-1:0] {
		NO_REQ     = 3'd0,
		R_REQ      = 3'd1,
		WB_REQ     = 3'd2,
		MEM_NO_MSG = 3'd4,
		MEM_READY  = 3'd5,
		MEM_SENT   = 3'd6
	} msg_t;

endpackage

// ==== verilog/lx_way_ram.sv ====
// Block RAM holding one way of stored lines, registered read with old data
`timescale 1ns/1ps

module lx_way_ram
	import lx_line_pkg::*;
#(
	parameter int DATA_WIDTH = 32,
	parameter int OFFSET_BITS = 2,
	parameter int INDEX_BITS = 4,
	parameter int ADDRESS_WIDTH = 32,
	localparam int TAG_BITS = ADDRESS_WIDTH - INDEX_BITS - OFFSET_BITS,
	localparam int LINE_WIDTH = STATUS_BITS + TAG_BITS + (DATA_WIDTH << OFFSET_BITS),
	localparam int DEPTH = 1 << INDEX_BITS
) (
	input logic clock,
	input logic we,
	input logic [INDEX_BITS-1:0] index,
	input logic [LINE_WIDTH-1:0] wdata,
	output logic [LINE_WIDTH-1:0] rdata
);

	logic [LINE_WIDTH-1:0] mem [DEPTH];

	always_ff @(posedge clock) begin
		if (we)
			mem[index] <= wdata;
		// Read before write on the same index
		rdata <= mem[index];
	end

endmodule
